/* compile.f */
rtl/rmw_isa_pkg.sv
rtl/rmw_pipe_pkg.sv
rtl/inst_queue.sv
rtl/reg_file.sv
rtl/rmw_alu.sv
rtl/operand_bypass.sv
rtl/rmw_pipe.sv
rtl/rmw_top.sv
verification/rmw_tb.sv

/* Bender.yml */
package:
  name: rmw_pipe

sources:
  - files:
      - rtl/rmw_isa_pkg.sv
      - rtl/rmw_pipe_pkg.sv
      - rtl/inst_queue.sv
      - rtl/reg_file.sv
      - rtl/rmw_alu.sv
      - rtl/operand_bypass.sv
      - rtl/rmw_pipe.sv
      - rtl/rmw_top.sv
  - target: test
    files:
      - verification/rmw_tb.sv

/* verification/rmw_tb.sv */
`timescale 1ns/1ns

module rmw_tb;
  import rmw_isa_pkg::*;
  import rmw_pipe_pkg::*;

  localparam int QUEUE_DEPTH = 16;
  localparam int PIPE_STAGES = 3;
  localparam int CLK_PERIOD  = 8;
  localparam int DRV_DLY     = 1;
  localparam int NUM_TESTS   = 5;
  localparam logic [31:0] SEED = 32'h4306;

  // one table row, stimulus plus the writeback it must produce
  typedef struct packed {
    logic [3:0] test;
    rmw_req_t   req;
    wb_t        exp;
  } entry_t;

  logic        clk;
  logic        rst;
  logic        in_valid;
  logic        in_ready;
  rmw_req_t    in_req;
  logic        out_valid;
  logic        out_ready;
  wb_t         out_wb;

  entry_t      stim_q [$];
  wb_t         exp_q [$];
  word_t       model_rf [16];
  logic [31:0] build_rng;
  logic [31:0] gap_rng;
  logic [31:0] rdy_rng;
  logic        built;
  logic        rand_gap;
  logic        rand_rdy;
  logic        hold_rdy;
  logic        prev_wait;
  wb_t         prev_wb;
  int          err_count;
  int          check_count;
  int          accept_count;
  string       names [NUM_TESTS] = '{"reset", "opcodes", "dependent", "random_ready",
                                     "backpressure"};

  rmw_top #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
  ) uut (
      .clk       (clk)
    , .rst       (rst)
    , .in_valid  (in_valid)
    , .in_ready  (in_ready)
    , .in_req    (in_req)
    , .out_valid (out_valid)
    , .out_ready (out_ready)
    , .out_wb    (out_wb)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // architectural result of one instruction
  function automatic word_t alu_model(input opcode_t op, input word_t a, input word_t b,
                                      input word_t imm);
    case (op)
      OP_AND:  return a & b;
      OP_NOT:  return ~a;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_MOV1: return b;
      OP_MOVI: return imm;
      // mov0 and every unlisted code
      default: return a;
    endcase
  endfunction

  task automatic note_error(input string msg);
    $display("%s", msg);
    err_count++;
  endtask

  // run one instruction through the model and append it to the table
  task automatic add_entry(input int test, input logic [3:0] opc, input reg_t wa,
                           input reg_t ra0, input reg_t ra1, input word_t imm);
    entry_t e;
    word_t  res;
    res = alu_model(opcode_t'(opc), model_rf[ra0], model_rf[ra1], imm);
    model_rf[wa]    = res;
    e.test          = test;
    e.req.inst.op   = opcode_t'(opc);
    e.req.inst.wa   = wa;
    e.req.inst.ra[0] = ra0;
    e.req.inst.ra[1] = ra1;
    e.req.imm       = imm;
    e.exp.wa        = wa;
    e.exp.wdata     = res;
    stim_q.push_back(e);
  endtask

  task automatic build_stimulus();
    logic [3:0] opc;
    reg_t       wa;
    reg_t       ra0;
    reg_t       ra1;
    for (int i = 0; i < 16; i++)
      model_rf[i] = '0;
    // every register reads back zero after reset
    // each one is read before anything writes it
    for (int i = 0; i < 16; i++)
      add_entry(1, OP_MOV0, reg_t'(i), reg_t'(i), reg_t'(i), 32'hdead_0000 + i);
    add_entry(2, OP_MOVI, 1, 0, 0, 32'hffff_fff0);
    add_entry(2, OP_MOVI, 2, 0, 0, 32'h0000_0025);
    add_entry(2, OP_MOVI, 3, 0, 0, 32'h8000_0001);
    add_entry(2, OP_AND, 4, 1, 2, 0);
    add_entry(2, OP_NOT, 5, 2, 0, 0);
    add_entry(2, OP_OR, 6, 1, 2, 0);
    add_entry(2, OP_XOR, 7, 3, 1, 0);
    // carry out of bit 31 is dropped
    add_entry(2, OP_ADD, 8, 1, 2, 0);
    add_entry(2, OP_ADD, 9, 3, 3, 0);
    // borrow wraps below zero
    add_entry(2, OP_SUB, 10, 2, 1, 0);
    add_entry(2, OP_SUB, 11, 0, 2, 0);
    add_entry(2, OP_MOV0, 12, 3, 2, 0);
    add_entry(2, OP_MOV1, 13, 3, 2, 0);
    // unassigned code behaves as mov0
    add_entry(2, 4'hc, 14, 7, 1, 0);
    // each one reads the destination just ahead (s3 bypass)
    // and the one two ahead (write-first read)
    add_entry(3, OP_MOVI, 1, 0, 0, 32'h0000_0007);
    add_entry(3, OP_ADD, 2, 1, 1, 0);
    add_entry(3, OP_SUB, 3, 2, 1, 0);
    add_entry(3, OP_XOR, 1, 3, 2, 0);
    add_entry(3, OP_ADD, 1, 1, 1, 0);
    add_entry(3, OP_OR, 4, 1, 3, 0);
    add_entry(3, OP_NOT, 4, 4, 0, 0);
    add_entry(3, OP_MOV1, 5, 0, 4, 0);
    add_entry(3, OP_AND, 6, 5, 1, 0);
    add_entry(3, OP_SUB, 6, 6, 5, 0);
    // random mix, codes 0 to 9
    for (int i = 0; i < 24; i++)
    begin
      build_rng = xorshift(build_rng);
      opc = build_rng % 10;
      wa  = build_rng[7:4];
      ra0 = build_rng[11:8];
      ra1 = build_rng[15:12];
      build_rng = xorshift(build_rng);
      add_entry(4, opc, wa, ra0, ra1, build_rng);
    end
    // long chain, more than the queue and pipe can hold
    for (int i = 0; i < 24; i++)
    begin
      if (i % 4 == 0)
        add_entry(5, OP_MOVI, reg_t'(i), 0, 0, 32'h1111_1111 * i);
      else
        add_entry(5, OP_ADD, reg_t'(i), reg_t'(i - 1), reg_t'(i + 5), 0);
    end
  endtask

  // called at the drive point, returns at the drive point after the transfer
  task automatic drive_req(input rmw_req_t req);
    in_req   = req;
    in_valid = 1'b1;
    @(negedge clk);
    while (!in_ready)
      @(negedge clk);
    @(posedge clk);
    #DRV_DLY;
    in_valid = 1'b0;
    accept_count++;
  endtask

  task automatic apply_test(input int t);
    int gap;
    foreach (stim_q[i])
    begin
      if (stim_q[i].test == t)
      begin
        gap = 0;
        if (rand_gap)
        begin
          gap_rng = xorshift(gap_rng);
          gap = gap_rng[2] ? 0 : gap_rng[1:0];
        end
        repeat (gap)
        begin
          @(posedge clk);
          #DRV_DLY;
        end
        exp_q.push_back(stim_q[i].exp);
        drive_req(stim_q[i].req);
      end
    end
  endtask

  // queue plus the three stages fill, then in_ready must stay low
  task automatic check_backpressure();
    int base;
    int low_run;
    int cyc;
    base    = accept_count;
    low_run = 0;
    cyc     = 0;
    while (low_run < 8 && cyc < 200)
    begin
      @(negedge clk);
      cyc++;
      low_run = in_ready ? 0 : low_run + 1;
    end
    check_count++;
    if (low_run < 8)
      note_error("in_ready never fell while out_ready was held low");
    else if (accept_count - base != QUEUE_DEPTH + PIPE_STAGES)
      note_error($sformatf("error: accepted = 0x%0h, expected 0x%0h",
                           accept_count - base, QUEUE_DEPTH + PIPE_STAGES));
    hold_rdy = 1'b0;
  endtask

  task automatic wait_drain(input int t);
    int cyc;
    int max_cycles;
    cyc        = 0;
    max_cycles = 0;
    foreach (stim_q[i])
      if (stim_q[i].test == t)
        max_cycles += 40;
    while (exp_q.size() != 0 && cyc < max_cycles)
    begin
      @(negedge clk);
      cyc++;
    end
    check_count++;
    if (exp_q.size() != 0)
    begin
      note_error($sformatf("%0d writebacks never appeared", exp_q.size()));
      exp_q.delete();
    end
    @(posedge clk);
    #DRV_DLY;
  endtask

  task automatic compare_wb(input wb_t exp);
    if (out_wb.wa !== exp.wa)
      note_error($sformatf("error: out_wb.wa = 0x%h, expected 0x%h", out_wb.wa, exp.wa));
    if (out_wb.wdata !== exp.wdata)
      note_error($sformatf("error: out_wb.wdata = 0x%h, expected 0x%h",
                           out_wb.wdata, exp.wdata));
  endtask

  initial
  begin
    clk = 1'b0;
    forever
      #(CLK_PERIOD / 2) clk = ~clk;
  end

  // out_ready follows the mode of the running test
  initial
  begin
    forever
    begin
      @(posedge clk);
      #DRV_DLY;
      if (hold_rdy)
        out_ready = 1'b0;
      else if (rand_rdy)
      begin
        rdy_rng   = xorshift(rdy_rng);
        out_ready = rdy_rng[4];
      end
      else
        out_ready = 1'b1;
    end
  end

  // sampled mid-cycle, a handshake seen here completes on the next rising edge
  always @(negedge clk)
  begin
    if (!rst)
    begin
      // a waiting writeback comes back unchanged
      if (prev_wait)
      begin
        check_count++;
        if (!out_valid)
          note_error("out_valid dropped before out_ready took the writeback");
        else if (out_wb !== prev_wb)
          note_error($sformatf("error: out_wb = 0x%h, expected 0x%h", out_wb, prev_wb));
      end
      if (out_valid && out_ready)
      begin
        check_count++;
        if (exp_q.size() == 0)
          note_error("writeback appeared with nothing left to expect");
        else
          compare_wb(exp_q.pop_front());
      end
      prev_wait = out_valid && !out_ready;
      prev_wb   = out_wb;
    end
  end

  initial
  begin
    wait (built === 1'b1);
    #((stim_q.size() * 40 + 16) * CLK_PERIOD);
    $display("timeout: run did not complete within the cycle budget");
    $display("Checks failed");
    $finish;
  end

  initial
  begin
    int errs_before;
    rst          = 1'b1;
    in_valid     = 1'b0;
    in_req       = '0;
    out_ready    = 1'b0;
    hold_rdy     = 1'b0;
    rand_gap     = 1'b0;
    rand_rdy     = 1'b0;
    prev_wait    = 1'b0;
    prev_wb      = '0;
    err_count    = 0;
    check_count  = 0;
    accept_count = 0;
    built        = 1'b0;
    build_rng    = SEED;
    gap_rng      = xorshift(SEED);
    rdy_rng      = xorshift(gap_rng);
    build_stimulus();
    built = 1'b1;
    repeat (16)
      @(posedge clk);
    #DRV_DLY;
    rst = 1'b0;
    // idle state right after reset
    @(negedge clk);
    check_count += 2;
    if (out_valid !== 1'b0)
      note_error($sformatf("error: out_valid = 0x%h, expected 0x0", out_valid));
    if (in_ready !== 1'b1)
      note_error($sformatf("error: in_ready = 0x%h, expected 0x1", in_ready));
    @(posedge clk);
    #DRV_DLY;
    for (int t = 1; t <= NUM_TESTS; t++)
    begin
      errs_before = err_count;
      rand_gap    = (t == 4);
      rand_rdy    = (t == 4);
      if (t == 5)
      begin
        hold_rdy = 1'b1;
        @(posedge clk);
        #DRV_DLY;
        fork
          apply_test(t);
          check_backpressure();
        join
      end
      else
        apply_test(t);
      wait_drain(t);
      $display("test %0d %s: %s, %0d errors", t, names[t - 1],
               (err_count == errs_before) ? "ok" : "FAIL", err_count - errs_before);
    end
    $display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, check_count, err_count);
    if (err_count == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

/* rtl/rmw_top.sv */
`timescale 1ns/1ns

module rmw_top #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                   clk
  , input  logic                   rst
  , input  logic                   in_valid
  , output logic                   in_ready
  , input  rmw_pipe_pkg::rmw_req_t in_req
  , output logic                   out_valid
  , input  logic                   out_ready
  , output rmw_pipe_pkg::wb_t      out_wb
);
  import rmw_isa_pkg::*;
  import rmw_pipe_pkg::*;

  // queue head to pipeline
  logic        q_valid;
  logic        q_ready;
  rmw_req_t    q_req;

  // register file read side
  logic [1:0]  rf_ren;
  reg_t [1:0]  rf_ra;
  word_t [1:0] rf_rdata;

  // register file write side
  logic        rf_wen;
  wb_t         rf_wr;

  inst_queue #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_queue (
      .clk      (clk)
    , .rst      (rst)
    , .in_valid (in_valid)
    , .in_ready (in_ready)
    , .in_req   (in_req)
    , .q_valid  (q_valid)
    , .q_ready  (q_ready)
    , .q_req    (q_req)
  );

  rmw_pipe u_pipe (
      .clk       (clk)
    , .rst       (rst)
    , .q_valid   (q_valid)
    , .q_ready   (q_ready)
    , .q_req     (q_req)
    , .rf_ren    (rf_ren)
    , .rf_ra     (rf_ra)
    , .rf_rdata  (rf_rdata)
    , .rf_wen    (rf_wen)
    , .rf_wr     (rf_wr)
    , .out_valid (out_valid)
    , .out_ready (out_ready)
    , .out_wb    (out_wb)
  );

  reg_file u_rf (
      .clk   (clk)
    , .rst   (rst)
    , .ren   (rf_ren)
    , .ra    (rf_ra)
    , .rdata (rf_rdata)
    , .wen   (rf_wen)
    , .wr    (rf_wr)
  );

endmodule

/* rtl/rmw_pipe.sv */
`timescale 1ns/1ns

module rmw_pipe (
    input  logic                          clk
  , input  logic                          rst
  , input  logic                          q_valid
  , output logic                          q_ready
  , input  rmw_pipe_pkg::rmw_req_t        q_req
  , output logic [1:0]                    rf_ren
  , output rmw_isa_pkg::reg_t [1:0]       rf_ra
  , input  rmw_isa_pkg::word_t [1:0]      rf_rdata
  , output logic                          rf_wen
  , output rmw_pipe_pkg::wb_t             rf_wr
  , output logic                          out_valid
  , input  logic                          out_ready
  , output rmw_pipe_pkg::wb_t             out_wb
);
  import rmw_isa_pkg::*;
  import rmw_pipe_pkg::*;

  // stage valid bits
  logic        s1_valid;
  logic        s2_valid;
  logic        s3_valid;

  // stage payloads
  rmw_req_t    s1_r;
  rmw_req_t    s2_r;
  wb_t         s3_r;

  // s2 record with operands straight from the register file
  stage_t      s2;

  // resolved operands and execute result
  word_t [1:0] opnd;
  word_t       result;

  // single global stall from output back-pressure
  logic        stall;
  logic        s1_adv;
  logic        s2_adv;
  logic        q_fire;

  // only a waiting result in s3 holds the pipe
  // bubbles in s1 and s2 hold along with it
  assign stall   = s3_valid & ~out_ready;

  assign q_ready = ~stall;
  assign q_fire  = q_valid & q_ready;
  assign s1_adv  = s1_valid & ~stall;
  assign s2_adv  = s2_valid & ~stall;

  // s1 issues the register read as it moves into s2
  // data lands in the register file output one cycle later
  assign rf_ren  = {2{s1_adv}};
  assign rf_ra   = s1_r.inst.ra;

  // assemble the s2 record
  always_comb
  begin
    s2.inst  = s2_r.inst;
    s2.imm   = s2_r.imm;
    s2.rdata = rf_rdata;
  end

  operand_bypass u_bypass (
      .s2       (s2)
    , .s3_valid (s3_valid)
    , .s3_wb    (s3_r)
    , .opnd     (opnd)
  );

  rmw_alu u_alu (
      .op     (s2_r.inst.op)
    , .imm    (s2_r.imm)
    , .opnd   (opnd)
    , .result (result)
  );

  // s3 drives the output port
  assign out_valid = s3_valid;
  assign out_wb    = s3_r;

  // commit happens exactly on the output handshake
  assign rf_wen    = out_valid & out_ready;
  assign rf_wr     = s3_r;

  // valid bits
  // all stages hold together under stall
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end
    else if (!stall)
    begin
      s1_valid <= q_valid;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
    end
  end

  // payload registers
  // loaded only when a valid entry advances
  always_ff @(posedge clk)
  begin
    if (q_fire)
      s1_r <= q_req;
    if (s1_adv)
      s2_r <= s1_r;
    if (s2_adv)
    begin
      s3_r.wa    <= s2_r.inst.wa;
      s3_r.wdata <= result;
    end
  end

  // a pending writeback neither drops nor changes until taken
  a_out_hold : assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_wb))
  );

endmodule

/* rtl/operand_bypass.sv */
`timescale 1ns/1ns

module operand_bypass (
    input  rmw_pipe_pkg::stage_t     s2
  , input  logic                     s3_valid
  , input  rmw_pipe_pkg::wb_t        s3_wb
  , output rmw_isa_pkg::word_t [1:0] opnd
);

  // per-operand hit on the s3 destination
  logic [1:0] hit;

  // s3 holds the only result not yet in the register file
  // anything older was written before s2 read it or via write-first
  always_comb
  begin
    for (int i = 0; i < 2; i++)
    begin
      hit[i] = s3_valid && (s3_wb.wa == s2.inst.ra[i]);
    end
  end

  always_comb
  begin
    for (int i = 0; i < 2; i++)
    begin
      if (hit[i])
        opnd[i] = s3_wb.wdata;
      else
        opnd[i] = s2.rdata[i];
    end
  end

endmodule

/* rtl/rmw_alu.sv */
`timescale 1ns/1ns

module rmw_alu (
    input  rmw_isa_pkg::opcode_t     op
  , input  rmw_isa_pkg::imm_t        imm
  , input  rmw_isa_pkg::word_t [1:0] opnd
  , output rmw_isa_pkg::word_t       result
);
  import rmw_isa_pkg::*;

  always_comb
  begin
    case (op)
      OP_AND:
        result = opnd[0] & opnd[1];
      OP_NOT:
        result = ~opnd[0];
      OP_OR:
        result = opnd[0] | opnd[1];
      OP_XOR:
        result = opnd[0] ^ opnd[1];
      // add and sub wrap at 32 bits
      OP_ADD:
        result = opnd[0] + opnd[1];
      OP_SUB:
        result = opnd[0] - opnd[1];
      OP_MOV0:
        result = opnd[0];
      OP_MOV1:
        result = opnd[1];
      // immediate load ignores both sources
      OP_MOVI:
        result = imm;
      // unknown opcodes behave as mov0
      default:
        result = opnd[0];
    endcase
  end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
    input  logic                          clk
  , input  logic                          rst
  , input  logic [1:0]                    ren
  , input  rmw_isa_pkg::reg_t [1:0]       ra
  , output rmw_isa_pkg::word_t [1:0]      rdata
  , input  logic                          wen
  , input  rmw_pipe_pkg::wb_t             wr
);
  import rmw_isa_pkg::*;

  localparam int NUM_REGS = 2 ** $bits(reg_t);

  word_t mem [NUM_REGS];

  // write port
  // every register starts at zero
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < NUM_REGS; i++)
        mem[i] <= '0;
    end
    else if (wen)
    begin
      mem[wr.wa] <= wr.wdata;
    end
  end

  // registered read ports
  // output only moves when enabled so a stalled consumer keeps its operands
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdata <= '0;
    end
    else
    begin
      for (int i = 0; i < 2; i++)
      begin
        if (ren[i])
        begin
          // write-first on an address collision
          if (wen && (wr.wa == ra[i]))
            rdata[i] <= wr.wdata;
          else
            rdata[i] <= mem[ra[i]];
        end
      end
    end
  end

endmodule

/* rtl/inst_queue.sv */
`timescale 1ns/1ns

module inst_queue #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                   clk
  , input  logic                   rst
  , input  logic                   in_valid
  , output logic                   in_ready
  , input  rmw_pipe_pkg::rmw_req_t in_req
  , output logic                   q_valid
  , input  logic                   q_ready
  , output rmw_pipe_pkg::rmw_req_t q_req
);
  import rmw_pipe_pkg::*;

  localparam int AW = $clog2(QUEUE_DEPTH);

  // storage, no reset needed
  rmw_req_t     mem [QUEUE_DEPTH];

  // pointers with an extra wrap bit on top
  logic [AW:0]  wr_ptr_r;
  logic [AW:0]  rd_ptr_r;
  logic [AW:0]  rd_ptr_w;
  logic [AW:0]  used;

  logic         wr_en;
  logic         rd_en;
  logic         full;
  logic         empty_r;

  // full when indices match but wrap bits differ
  assign full     = (wr_ptr_r[AW] != rd_ptr_r[AW]) &&
                    (wr_ptr_r[AW-1:0] == rd_ptr_r[AW-1:0]);
  assign in_ready = ~full;
  assign wr_en    = in_valid & in_ready;

  // head becomes visible one cycle after the write
  assign q_valid  = ~empty_r;
  assign q_req    = mem[rd_ptr_r[AW-1:0]];
  assign rd_en    = q_valid & q_ready;

  assign rd_ptr_w = rd_en ? rd_ptr_r + 1'b1 : rd_ptr_r;

  // occupancy, only watched by the checks below
  assign used     = wr_ptr_r - rd_ptr_r;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      empty_r  <= 1'b1;
    end
    else
    begin
      if (wr_en)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      rd_ptr_r <= rd_ptr_w;
      // compared against the old write pointer
      // so a fresh entry shows up a cycle later and a pop is seen at once
      empty_r  <= (rd_ptr_w == wr_ptr_r);
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr_r[AW-1:0]] <= in_req;
  end

  // never more entries held than slots
  a_no_overflow : assert property (
    @(posedge clk) disable iff (rst) used <= QUEUE_DEPTH
  );

  // registered empty flag must never let a pop through on an empty queue
  a_no_underflow : assert property (
    @(posedge clk) disable iff (rst) rd_en |-> (rd_ptr_r != wr_ptr_r)
  );

endmodule

/* rtl/rmw_pipe_pkg.sv */
package rmw_pipe_pkg;

  // input port payload, 48 bits
  typedef struct packed {
    rmw_isa_pkg::inst_t inst;
    rmw_isa_pkg::imm_t  imm;
  } rmw_req_t;

  // writeback bundle, 36 bits
  // shared by the output port and the register file write port
  typedef struct packed {
    rmw_isa_pkg::reg_t  wa;
    rmw_isa_pkg::word_t wdata;
  } wb_t;

  // per-stage record, 112 bits
  // rdata holds the two source operands as read from the register file
  typedef struct packed {
    rmw_isa_pkg::inst_t       inst;
    rmw_isa_pkg::imm_t        imm;
    rmw_isa_pkg::word_t [1:0] rdata;
  } stage_t;

endpackage

/* rtl/rmw_isa_pkg.sv */
package rmw_isa_pkg;

  // register address, sixteen architectural registers
  typedef logic [3:0] reg_t;

  // datapath word
  typedef logic [31:0] word_t;

  // immediate carried alongside each instruction
  typedef logic [31:0] imm_t;

  // opcode encoding
  // unlisted codes execute as a move of operand 0
  typedef enum logic [3:0] {
    OP_AND  = 4'h0,
    OP_NOT  = 4'h1,
    OP_OR   = 4'h2,
    OP_XOR  = 4'h3,
    OP_ADD  = 4'h4,
    OP_SUB  = 4'h5,
    OP_MOV0 = 4'h6,
    OP_MOV1 = 4'h7,
    OP_MOVI = 4'h8
  } opcode_t;

  // instruction word, 16 bits
  // ra[0] and ra[1] are the two source registers
  typedef struct packed {
    reg_t [1:0] ra;
    reg_t       wa;
    opcode_t    op;
  } inst_t;

endpackage
